//--- bench/file_io_properties.sv
/*
 * stream handshake properties
 * concurrent checks on the top level rx and tx character streams,
 * bound into file_io_top from the testbench
 */
module file_io_properties (
  input logic                      clk_sys,
  input logic                      rst_clk,
  input logic                      rx_ready_o,
  input file_io_pkg::char_stream_t tx_o,
  input logic                      tx_ready_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned err_cnt = 0;               // read by the testbench

  //**************************************************************************
  // tx side
  //**************************************************************************
  // stalled character keeps valid and data
  property tx_hold_p;
    @(posedge clk_sys) disable iff (rst_clk)
      (tx_o.valid && !tx_ready_i) |=> (tx_o.valid && $stable(tx_o.data));
  endproperty

  // loader input is closed while dump output waits
  property rx_closed_p;
    @(posedge clk_sys) disable iff (rst_clk)
      tx_o.valid |-> !rx_ready_o;
  endproperty

  //**************************************************************************
  // reset values
  //**************************************************************************
  property tx_quiet_in_reset_p;
    @(posedge clk_sys) rst_clk |=> !tx_o.valid;
  endproperty

  property rx_open_after_reset_p;
    @(posedge clk_sys) rst_clk |=> rx_ready_o;
  endproperty

  tx_hold_a: assert property (tx_hold_p)
  else
  begin
    $error("tx_o changed or dropped while stalled");
    err_cnt++;
  end

  rx_closed_a: assert property (rx_closed_p)
  else
  begin
    $error("rx_ready_o high while a tx character is pending");
    err_cnt++;
  end

  tx_quiet_in_reset_a: assert property (tx_quiet_in_reset_p)
  else
  begin
    $error("tx_o valid during reset");
    err_cnt++;
  end

  rx_open_after_reset_a: assert property (rx_open_after_reset_p)
  else
  begin
    $error("rx_ready_o low during reset");
    err_cnt++;
  end

endmodule

//--- bench/file_io_tb.sv
/*
 * file i/o testbench
 * loads both memories from framed hex text, dumps them back and
 * compares every output character with text built from a word model
 */
module file_io_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import file_io_pkg::*;

  localparam int RX_TIMEOUT = 1000;       // cycles waiting for rx ready
  localparam int TX_TIMEOUT = 1000;       // cycles without a tx transfer

  logic         clk_sys;
  logic         rst_clk;
  char_stream_t rx_i;
  logic         rx_ready_o;
  char_stream_t tx_o;
  logic         tx_ready_i;
  logic         start_dump_i;

  logic [31:0]  rng;                      // xorshift state
  logic [31:0]  model [2][8];             // expected memory words
  char_t        expect_q [$];             // expected dump text
  logic         quiet_watch;              // tx must stay idle

  file_io_top file_io_top_i (
    .clk_sys      (clk_sys),
    .rst_clk      (rst_clk),
    .rx_i         (rx_i),
    .rx_ready_o   (rx_ready_o),
    .tx_o         (tx_o),
    .tx_ready_i   (tx_ready_i),
    .start_dump_i (start_dump_i)
  );

  bind file_io_top file_io_properties file_io_properties_i (
    .clk_sys      (clk_sys),
    .rst_clk      (rst_clk),
    .rx_ready_o   (rx_ready_o),
    .tx_o         (tx_o),
    .tx_ready_i   (tx_ready_i)
  );

  initial
  begin
    clk_sys = 1'b0;
    forever #50 clk_sys = ~clk_sys;       // 100 ns period
  end

  //**************************************************************************
  // helpers
  //**************************************************************************
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // ascii digit, case selectable
  function automatic char_t hex_char(input logic [3:0] n, input bit upper);
    if (n < 4'd10)
      return 8'h30 + 8'(n);
    else if (upper)
      return 8'h41 + 8'(n) - 8'd10;
    else
      return 8'h61 + 8'(n) - 8'd10;
  endfunction

  function automatic char_t junk_char(input logic [2:0] i);
    string pool = "gxzG:-/ ";             // none of these is hex
    return char_t'(pool[i]);
  endfunction

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // called at a falling edge, returns one falling edge after the transfer
  task automatic send_char(input char_t c);
    int waited = 0;
    rx_i = '{valid: 1'b1, data: c};
    while (!rx_ready_o)
    begin
      @(negedge clk_sys);
      waited++;
      if (waited > RX_TIMEOUT)
        report_failure("timeout, rx_ready_o stayed low while sending a file");
    end
    @(negedge clk_sys);
  endtask

  task automatic send_file(input char_t name, input int mem, input bit store,
                           input bit upper, input bit junk, input int pulse_at);
    logic [31:0] w;
    int          n;
    int          idx;
    n   = (mem == 1) ? 4 : 8;             // digits per row
    idx = 0;
    send_char(CHR_SOH);
    send_char(name);
    send_char(CHR_EOT);
    send_char(CHR_SOT);
    for (int a = 0; a < 8; a++)
    begin
      rng = xorshift(rng);
      w   = (n == 4) ? {16'h0000, rng[15:0]} : rng;
      if (store)
        model[mem][a] = w;
      for (int d = n - 1; d >= 0; d--)
      begin
        rng = xorshift(rng);
        if (junk && rng[0])
          send_char(junk_char(rng[3:1]));
        start_dump_i = (idx == pulse_at);  // one cycle, mid load
        send_char(hex_char(w[4*d +: 4], upper));
        start_dump_i = 1'b0;
        idx++;
      end
      send_char(CHR_CR);
      send_char(CHR_LF);
    end
    rx_i.valid = 1'b0;
  endtask

  // framed text for both memories from the model
  task automatic build_expected();
    int n;
    expect_q.delete();
    for (int m = 0; m < 2; m++)
    begin
      n = (m == 1) ? 4 : 8;
      expect_q.push_back(CHR_SOH);
      expect_q.push_back(hex_char(4'(m), 1'b1));
      expect_q.push_back(CHR_EOT);
      expect_q.push_back(CHR_SOT);
      for (int a = 0; a < 8; a++)
      begin
        for (int d = n - 1; d >= 0; d--)
          expect_q.push_back(hex_char(model[m][a][4*d +: 4], 1'b1));
        expect_q.push_back(CHR_CR);
        expect_q.push_back(CHR_LF);
      end
      expect_q.push_back(CHR_EOF);
    end
  endtask

  task automatic run_dump(input bit gaps);
    int    idle = 0;
    char_t c;
    build_expected();
    start_dump_i = 1'b1;
    @(negedge clk_sys);
    start_dump_i = 1'b0;
    while (expect_q.size() > 0)
    begin
      rng        = xorshift(rng);
      tx_ready_i = gaps ? (rng[1:0] != 2'b00) : 1'b1;
      assert (!rx_ready_o)
      else
        report_failure($sformatf("[FAIL] rx_ready_o 0x%h expected 0x0", rx_ready_o));
      if (tx_o.valid && tx_ready_i)     // transfers on the next rising edge
      begin
        c = expect_q.pop_front();
        assert (tx_o.data == c)
        else
          report_failure($sformatf("[FAIL] tx_o.data 0x%02h expected 0x%02h",
                                   tx_o.data, c));
        idle = 0;
      end
      else
      begin
        idle++;
        if (idle > TX_TIMEOUT)
          report_failure("timeout, no dump character arrived");
      end
      @(negedge clk_sys);
    end
    tx_ready_i = 1'b0;
    // nothing left after the last EOF
    assert (!tx_o.valid)
    else
      report_failure($sformatf("[FAIL] tx_o.valid 0x%h expected 0x0", tx_o.valid));
    assert (rx_ready_o)
    else
      report_failure($sformatf("[FAIL] rx_ready_o 0x%h expected 0x1", rx_ready_o));
  endtask

  // watch for stray output and for bound property failures
  always @(negedge clk_sys)
  begin
    if (quiet_watch)
      assert (!tx_o.valid)
      else
        report_failure($sformatf("[FAIL] tx_o.valid 0x%h expected 0x0", tx_o.valid));
    if (file_io_top_i.file_io_properties_i.err_cnt != 0)
      report_failure("a concurrent assertion on the stream handshakes failed");
  end

  //**************************************************************************
  // main sequence
  //**************************************************************************
  initial
  begin
    rx_i         = '0;
    tx_ready_i   = 1'b0;
    start_dump_i = 1'b0;
    rst_clk      = 1'b1;
    quiet_watch  = 1'b0;
    rng          = 32'hf830_d8e2;
    repeat (8) @(posedge clk_sys);
    @(negedge clk_sys);
    rst_clk = 1'b0;

    assert (!tx_o.valid)
    else
      report_failure($sformatf("[FAIL] tx_o.valid 0x%h expected 0x0", tx_o.valid));
    assert (rx_ready_o)
    else
      report_failure($sformatf("[FAIL] rx_ready_o 0x%h expected 0x1", rx_ready_o));

    send_file("0", 0, 1'b1, 1'b1, 1'b0, -1);   // upper case, clean rows
    send_file("1", 1, 1'b1, 1'b0, 1'b1, -1);   // lower case with junk
    send_file("7", 0, 1'b0, 1'b1, 1'b0, -1);   // bad name, ignored
    repeat (2) @(negedge clk_sys);
    run_dump(1'b0);
    run_dump(1'b1);                            // random tx gaps

    // start pulse while a load runs is dropped
    quiet_watch = 1'b1;
    send_file("1", 1, 1'b1, 1'b1, 1'b0, 6);
    repeat (20) @(negedge clk_sys);
    quiet_watch = 1'b0;
    @(negedge clk_sys);
    run_dump(1'b1);

    repeat (4) @(negedge clk_sys);
    if (file_io_top_i.file_io_properties_i.err_cnt != 0)
      report_failure("a concurrent assertion on the stream handshakes failed");
    else
    begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

//--- src/file_dumper.sv
/*
 * file dumper
 * on start walks both memories and sends each one as a framed hex file
 * header, one upper-case row per word with CR LF, then EOF
 */
module file_dumper (
  input  logic                      clk_sys,
  input  logic                      rst_clk,
  input  logic                      start_dump_i,  // one cycle pulse
  input  logic                      load_busy_i,
  output file_io_pkg::char_stream_t tx_o,
  input  logic                      tx_ready_i,
  output logic                      dump_busy_o,
  output file_io_pkg::mem_rd_t      rd_o,
  input  file_io_pkg::word_t        rd_word_i
);
  import file_io_pkg::*;

  dumper_state_e state_q;
  mem_sel_t      sel_q;                   // memory being sent
  addr_t         addr_q;                  // row being sent
  nib_cnt_t      dig_q;                   // digit within the row
  logic [1:0]    chr_cnt_q;               // header and eol position
  logic          tx_valid_q;
  char_t         tx_data_q;
  char_t         chr_next;
  nib_cnt_t      nib_pos;                 // nibble index, msb first
  logic          slot_free;
  logic          emit;
  logic          last_dig;

  // output register empty or draining this cycle
  assign slot_free = ~tx_valid_q | tx_ready_i;
  assign emit      = slot_free &
                     (state_q inside {DP_HEADER, DP_DIGITS, DP_EOL, DP_TRAILER});
  assign last_dig  = (dig_q == nib_cnt_t'(nibbles_of(sel_q) - 4'd1));
  assign nib_pos   = nib_cnt_t'(nibbles_of(sel_q) - 4'd1) - dig_q;

  //**************************************************************************
  // character select
  //**************************************************************************
  always_comb
  begin
    chr_next = CHR_EOF;
    case (state_q)
      DP_HEADER:
        case (chr_cnt_q)
          2'd0:    chr_next = CHR_SOH;
          2'd1:    chr_next = nibble_to_hex({3'b000, sel_q});   // file name
          2'd2:    chr_next = CHR_EOT;
          default: chr_next = CHR_SOT;
        endcase
      DP_DIGITS: chr_next = nibble_to_hex(rd_word_i[{nib_pos, 2'b00} +: 4]);
      DP_EOL:    chr_next = chr_cnt_q[0] ? CHR_LF : CHR_CR;
      default:   chr_next = CHR_EOF;    // trailer
    endcase
  end

  //**************************************************************************
  // sequencing
  //**************************************************************************
  always_ff @(posedge clk_sys)
  begin
    if (rst_clk)
    begin
      state_q    <= DP_IDLE;
      tx_valid_q <= 1'b0;
      sel_q      <= '0;
      addr_q     <= '0;
      dig_q      <= '0;
      chr_cnt_q  <= '0;
    end
    else
    begin
      if (emit)
        tx_valid_q <= 1'b1;
      else if (tx_ready_i)
        tx_valid_q <= 1'b0;
      case (state_q)
        DP_IDLE:
          // no restart while a load runs or the last EOF is still pending
          if (start_dump_i && !load_busy_i && !tx_valid_q)
          begin
            state_q   <= DP_HEADER;
            sel_q     <= '0;
            addr_q    <= '0;
            chr_cnt_q <= '0;
          end
        DP_HEADER:
          if (slot_free)
          begin
            chr_cnt_q <= chr_cnt_q + 1'b1;     // wraps to 0 after SOT
            if (chr_cnt_q == 2'd3)
              state_q <= DP_READ;
          end
        DP_READ:
          begin
            state_q <= DP_DIGITS;             // word arrives next cycle
            dig_q   <= '0;
          end
        DP_DIGITS:
          if (slot_free)
          begin
            if (last_dig)
            begin
              dig_q     <= '0;
              chr_cnt_q <= '0;
              state_q   <= DP_EOL;
            end
            else
            begin
              dig_q <= dig_q + 1'b1;
            end
          end
        DP_EOL:
          if (slot_free)
          begin
            chr_cnt_q <= chr_cnt_q + 1'b1;
            if (chr_cnt_q[0])                 // lf going out
            begin
              chr_cnt_q <= '0;
              if (addr_q == addr_t'(MEM_DEPTH - 1))
                state_q <= DP_TRAILER;
              else
              begin
                addr_q  <= addr_q + 1'b1;
                state_q <= DP_READ;
              end
            end
          end
        DP_TRAILER:
          if (slot_free)
          begin
            if (sel_q == mem_sel_t'(NUM_MEMS - 1))
              state_q <= DP_IDLE;             // busy holds until EOF moves
            else
            begin
              sel_q     <= sel_q + 1'b1;
              addr_q    <= '0;
              chr_cnt_q <= '0;
              state_q   <= DP_HEADER;
            end
          end
        default:
          state_q <= DP_IDLE;
      endcase
    end
  end

  // data only changes when the slot frees, so it holds while stalled
  always_ff @(posedge clk_sys)
  begin
    if (emit)
      tx_data_q <= chr_next;
  end

  assign tx_o        = '{valid: tx_valid_q, data: tx_data_q};
  assign rd_o        = '{en: (state_q == DP_READ), sel: sel_q, addr: addr_q};
  assign dump_busy_o = (state_q != DP_IDLE) | tx_valid_q;

endmodule

//--- src/file_io_pkg.sv
/*
 * file i/o shared definitions
 * framing characters, memory geometry, stream and memory port structs
 * and the hex digit conversion helpers used by loader and dumper
 */
package file_io_pkg;

  typedef logic [7:0] char_t;              // one stream character

  // framing characters
  localparam char_t CHR_SOH = 8'h01;       // start of header
  localparam char_t CHR_SOT = 8'h02;       // start of text
  localparam char_t CHR_EOT = 8'h03;       // end of header
  localparam char_t CHR_EOF = 8'h04;       // end of file
  localparam char_t CHR_LF  = 8'h0a;
  localparam char_t CHR_CR  = 8'h0d;

  //**************************************************************************
  // memory geometry
  //**************************************************************************
  localparam int NUM_MEMS     = 2;
  localparam int MEM_DEPTH    = 8;         // words per memory
  localparam int ADDR_W       = 3;
  localparam int WORD_W       = 32;        // widest memory
  localparam int MEM0_NIBBLES = 8;         // 32 bit rows
  localparam int MEM1_NIBBLES = 4;         // 16 bit rows

  typedef logic              mem_sel_t;
  typedef logic [2:0]        nib_cnt_t;    // digit index within a row
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;       // narrow memories use low bits

  typedef enum logic [2:0] {
    LD_IDLE, LD_NAME, LD_EOT, LD_SOT, LD_DATA
  } loader_state_e;

  typedef enum logic [2:0] {
    DP_IDLE, DP_HEADER, DP_READ, DP_DIGITS, DP_EOL, DP_TRAILER
  } dumper_state_e;

  typedef struct packed {
    logic  valid;
    char_t data;
  } char_stream_t;                         // 9 bits

  typedef struct packed {
    logic     en;
    mem_sel_t sel;
    addr_t    addr;
    word_t    data;
  } mem_wr_t;                              // 37 bits

  typedef struct packed {
    logic     en;
    mem_sel_t sel;
    addr_t    addr;
  } mem_rd_t;                              // 5 bits

  // bit 4 set when c is not 0-9, a-f or A-F
  function automatic logic [4:0] hex_to_nibble(input char_t c);
    if (c >= 8'h30 && c <= 8'h39)
      return {1'b0, c[3:0]};
    else if ((c >= 8'h41 && c <= 8'h46) || (c >= 8'h61 && c <= 8'h66))
      return {1'b0, c[3:0] + 4'd9};         // letters give 10 to 15
    else
      return 5'b1_0000;
  endfunction

  function automatic char_t nibble_to_hex(input logic [3:0] n);
    if (n <= 4'd9)
      return {4'h3, n};
    else
      return {4'h0, n} + 8'h37;             // upper case A-F
  endfunction

  function automatic logic [3:0] nibbles_of(input mem_sel_t s);
    return s ? 4'(MEM1_NIBBLES) : 4'(MEM0_NIBBLES);
  endfunction

endpackage

//--- src/file_io_top.sv
/*
 * file i/o top level
 * loader, dumper and the two-memory bank on one character stream pair
 */
module file_io_top (
  input  logic                      clk_sys,
  input  logic                      rst_clk,
  input  file_io_pkg::char_stream_t rx_i,          // file in
  output logic                      rx_ready_o,
  output file_io_pkg::char_stream_t tx_o,          // file out
  input  logic                      tx_ready_i,
  input  logic                      start_dump_i
);
  import file_io_pkg::*;

  mem_wr_t mem_wr;                        // loader to bank
  mem_rd_t mem_rd;                        // dumper to bank
  word_t   rd_word;                       // bank to dumper
  logic    load_busy;
  logic    dump_busy;

  // hex text in, words out
  file_loader file_loader_i (
    .clk_sys     (clk_sys),
    .rst_clk     (rst_clk),
    .rx_i        (rx_i),
    .rx_ready_o  (rx_ready_o),
    .dump_busy_i (dump_busy),
    .load_busy_o (load_busy),
    .wr_o        (mem_wr)
  );

  // words in, hex text out
  file_dumper file_dumper_i (
    .clk_sys      (clk_sys),
    .rst_clk      (rst_clk),
    .start_dump_i (start_dump_i),
    .load_busy_i  (load_busy),
    .tx_o         (tx_o),
    .tx_ready_i   (tx_ready_i),
    .dump_busy_o  (dump_busy),
    .rd_o         (mem_rd),
    .rd_word_i    (rd_word)
  );

  mem_bank mem_bank_i (
    .clk_sys   (clk_sys),
    .rst_clk   (rst_clk),
    .wr_i      (mem_wr),
    .rd_i      (mem_rd),
    .rd_word_o (rd_word)
  );

endmodule

//--- src/file_loader.sv
/*
 * file loader
 * parses SOH, name digit, EOT, SOT and hex rows from the rx stream,
 * packs digits into words and writes them to the selected memory
 */
module file_loader (
  input  logic                      clk_sys,
  input  logic                      rst_clk,
  input  file_io_pkg::char_stream_t rx_i,
  output logic                      rx_ready_o,
  input  logic                      dump_busy_i,   // stall input during dump
  output logic                      load_busy_o,
  output file_io_pkg::mem_wr_t      wr_o
);
  import file_io_pkg::*;

  loader_state_e state_q;
  mem_sel_t      sel_q;                   // target memory from the name
  addr_t         addr_q;                  // next word address
  nib_cnt_t      dig_q;                   // digits taken in this word
  word_t         shift_q;                 // word under assembly
  logic          wr_en_q;
  logic          rx_fire;
  logic [4:0]    hex;                     // decoded character
  logic          last_dig;

  assign rx_ready_o = ~dump_busy_i;       // one char per cycle otherwise
  assign rx_fire    = rx_i.valid & rx_ready_o;
  assign hex        = hex_to_nibble(rx_i.data);
  assign last_dig   = (dig_q == nib_cnt_t'(nibbles_of(sel_q) - 4'd1));

  //**************************************************************************
  // header parse and word counting
  //**************************************************************************
  always_ff @(posedge clk_sys)
  begin
    if (rst_clk)
    begin
      state_q <= LD_IDLE;
      wr_en_q <= 1'b0;
      sel_q   <= '0;
      addr_q  <= '0;
      dig_q   <= '0;
    end
    else
    begin
      wr_en_q <= 1'b0;                    // single cycle write strobe
      if (wr_en_q)
        addr_q <= addr_q + 1'b1;          // advance once the word lands
      if (rx_fire)
      begin
        case (state_q)
          LD_IDLE:
            if (rx_i.data == CHR_SOH)
              state_q <= LD_NAME;
          LD_NAME:
            // only names of existing memories, anything else drops the file
            if (!hex[4] && (hex[3:0] < NUM_MEMS))
            begin
              sel_q   <= mem_sel_t'(hex[0]);
              state_q <= LD_EOT;
            end
            else
            begin
              state_q <= LD_IDLE;
            end
          LD_EOT:
            state_q <= (rx_i.data == CHR_EOT) ? LD_SOT : LD_IDLE;
          LD_SOT:
            if (rx_i.data == CHR_SOT)
            begin
              state_q <= LD_DATA;
              addr_q  <= '0;
              dig_q   <= '0;
            end
            else
            begin
              state_q <= LD_IDLE;
            end
          LD_DATA:
            if (!hex[4])                  // cr, lf and junk skipped
            begin
              if (last_dig)
              begin
                dig_q   <= '0;
                wr_en_q <= 1'b1;          // write on the following edge
                if (addr_q == addr_t'(MEM_DEPTH - 1))
                  state_q <= LD_IDLE;     // last row of the file
              end
              else
              begin
                dig_q <= dig_q + 1'b1;
              end
            end
          default:
            state_q <= LD_IDLE;
        endcase
      end
    end
  end

  // msb digit first, so shift left
  always_ff @(posedge clk_sys)
  begin
    if (rx_fire && (state_q == LD_DATA) && !hex[4])
      shift_q <= {shift_q[WORD_W-5:0], hex[3:0]};
  end

  assign load_busy_o = (state_q != LD_IDLE) | wr_en_q;   // covers pending write
  assign wr_o = '{en: wr_en_q, sel: sel_q, addr: addr_q, data: shift_q};

endmodule

//--- src/mem_bank.sv
/*
 * memory bank
 * memory 0 is 32 bits wide, memory 1 is 16 bits wide, both 8 deep
 * one shared write port from the loader, one registered read port
 * for the dumper, read data zero-extended to a full word
 */
module mem_bank (
  input  logic                 clk_sys,
  input  logic                 rst_clk,
  input  file_io_pkg::mem_wr_t wr_i,       // loader write
  input  file_io_pkg::mem_rd_t rd_i,       // dumper read
  output file_io_pkg::word_t   rd_word_o   // valid the cycle after rd_i.en
);
  import file_io_pkg::*;

  //**************************************************************************
  // storage
  //**************************************************************************
  logic [4*MEM0_NIBBLES-1:0] mem0 [MEM_DEPTH];
  logic [4*MEM1_NIBBLES-1:0] mem1 [MEM_DEPTH];

  logic wr0;                               // write strobe per array
  logic wr1;

  assign wr0 = wr_i.en & (wr_i.sel == 1'b0);
  assign wr1 = wr_i.en & (wr_i.sel == 1'b1);

  // memory 0 takes the full word
  always_ff @(posedge clk_sys)
  begin
    if (wr0)
    begin
      mem0[wr_i.addr] <= wr_i.data[4*MEM0_NIBBLES-1:0];
    end
  end

  // memory 1 keeps only the low 16 bits
  always_ff @(posedge clk_sys)
  begin
    if (wr1)
    begin
      mem1[wr_i.addr] <= wr_i.data[4*MEM1_NIBBLES-1:0];
    end
  end

  //**************************************************************************
  // read port
  //**************************************************************************
  // word held until the next read enable
  always_ff @(posedge clk_sys)
  begin
    if (rst_clk)
    begin
      rd_word_o <= '0;
    end
    else if (rd_i.en)
    begin
      if (rd_i.sel)
        rd_word_o <= word_t'(mem1[rd_i.addr]);   // zero-extend 16 bits
      else
        rd_word_o <= word_t'(mem0[rd_i.addr]);
    end
  end

endmodule

//--- vlog.f
src/file_io_pkg.sv
src/mem_bank.sv
src/file_loader.sv
src/file_dumper.sv
src/file_io_top.sv
bench/file_io_properties.sv
bench/file_io_tb.sv
